// File: Makefile
# Verilator flow for the read dispatcher
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_rd_dispatch
RTL_TOP   ?= rd_dispatch_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --timing --assert
RTL_SRCS  ?= $(shell grep '^verilog/' $(FILELIST))
ALL_SRCS  := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(ALL_SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the log holds the pass line
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_rd_dispatch.sv
`default_nettype none
`timescale 1ns/1ns

module tb_rd_dispatch
    import rd_isa_pkg::*;
    import rd_cfg_pkg::*;
();

    localparam int PE_NUM      = 32;
    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 16;
    localparam int SEED        = 59;
    localparam int TEST_CYCLES = 40;
    localparam int TIMEOUT     = 6 * TEST_CYCLES + RST_CYCLES;

    logic              clk;
    logic              rst;
    logic              ins_valid;
    ins_word_u         ins;
    logic              ins_ready;
    layer_cfg_t        layer;
    logic              ibuf_done = 1'b1;
    logic              dbuf_done = 1'b1;

    logic              ibuf_start;
    ibuf_cfg_t         ibuf_cfg;
    logic [PE_NUM-1:0] ibuf_mask;
    logic              ibuf_ddr_sel;
    logic              dbuf_start;
    dbuf_cfg_t         dbuf_cfg;
    logic [PE_NUM-1:0] dbuf_mask;
    logic [1:0]        dbuf_ddr_sel;
    logic              ddr1_ready_sel;
    logic              ddr1_start;
    ddr_cmd_t          ddr1_cmd;
    logic              ddr2_start;
    ddr_cmd_t          ddr2_cmd;

    int err_cnt;
    int test_cnt;
    int test_err_base;
    int ibuf_wait = 0;
    int dbuf_wait = 0;

    rd_dispatch_top #(
        .PE_NUM (PE_NUM)
    ) i_rd_dispatch_top (
        .clk            (clk),
        .rst            (rst),
        .ins_valid      (ins_valid),
        .ins            (ins),
        .ins_ready      (ins_ready),
        .layer          (layer),
        .ibuf_done      (ibuf_done),
        .dbuf_done      (dbuf_done),
        .ibuf_start     (ibuf_start),
        .ibuf_cfg       (ibuf_cfg),
        .ibuf_mask      (ibuf_mask),
        .ibuf_ddr_sel   (ibuf_ddr_sel),
        .dbuf_start     (dbuf_start),
        .dbuf_cfg       (dbuf_cfg),
        .dbuf_mask      (dbuf_mask),
        .dbuf_ddr_sel   (dbuf_ddr_sel),
        .ddr1_ready_sel (ddr1_ready_sel),
        .ddr1_start     (ddr1_start),
        .ddr1_cmd       (ddr1_cmd),
        .ddr2_start     (ddr2_start),
        .ddr2_cmd       (ddr2_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // buffer engine models, busy 1 to 8 cycles per start

    always @(negedge clk) begin
        if (ibuf_start) begin
            ibuf_done <= 1'b0;
            ibuf_wait <= $urandom_range(8, 1);
        end else if (!ibuf_done) begin
            if (ibuf_wait <= 1) begin
                ibuf_done <= 1'b1;
            end else begin
                ibuf_wait <= ibuf_wait - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (dbuf_start) begin
            dbuf_done <= 1'b0;
            dbuf_wait <= $urandom_range(8, 1);
        end else if (!dbuf_done) begin
            if (dbuf_wait <= 1) begin
                dbuf_done <= 1'b1;
            end else begin
                dbuf_wait <= dbuf_wait - 1;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    // ==================================================
    // helpers

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAIL at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("%-12s %0d mismatches", name, err_cnt - test_err_base);
    endtask

    function automatic ins_word_u make_ins(input logic [3:0] op, input logic [5:0] buf_id,
                                           input logic [3:0] row, input logic [3:0] pix,
                                           input logic [7:0] size, input logic [31:0] addr);
        ins_word_u w;
        w            = '0;
        w.rd.opcode  = opcode_t'(op);
        w.rd.buf_id  = buf_id;
        w.rd.row_num = row;
        w.rd.pix_num = pix;
        w.rd.size    = size;
        w.rd.st_addr = addr;
        return w;
    endfunction

    function automatic layer_cfg_t rand_layer(input logic type_bit0);
        layer_cfg_t l;
        l.layer_type    = {3'($urandom), type_bit0};
        l.in_img_width  = 8'($urandom);
        l.out_img_width = 8'($urandom);
        l.in_ch_seg     = 4'($urandom);
        l.out_ch_seg    = 4'($urandom);
        l.depool        = 1'($urandom);
        return l;
    endfunction

    // layer must settle two cycles ahead of an instruction
    task automatic apply_layer(input layer_cfg_t l);
        layer <= l;
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ins_ready && n < TEST_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!ins_ready) begin
            $display("ins_ready did not return within %0d cycles", TEST_CYCLES);
            err_cnt++;
        end
    endtask

    // returns half a cycle after the accepting edge
    task automatic issue(input ins_word_u w, input logic hold);
        wait_ready();
        ins       <= w;
        ins_valid <= 1'b1;
        @(negedge clk);
        if (!hold) begin
            ins_valid <= 1'b0;
        end
        check_eq(64'(ins_ready), 64'd0, "ins_ready low after accept");
    endtask

    task automatic check_strided(input ddr_cmd_t cmd, input logic [31:0] addr,
                                 input logic [3:0] pix, input logic [3:0] seg,
                                 input logic [7:0] width, input logic [3:0] rows,
                                 input string tag);
        int exp_burst;
        int exp_step;
        exp_burst = ((int'(pix) + 1) * (int'(seg) + 1)) << LINE_SHIFT;
        exp_step  = ((int'(pix) + 1) * (int'(width) + 1)) << LINE_SHIFT;
        check_eq(64'(cmd.st_addr), 64'(addr), {tag, " st_addr"});
        check_eq(64'(cmd.burst), 64'(exp_burst), {tag, " burst"});
        check_eq(64'(cmd.step), 64'(exp_step), {tag, " step"});
        check_eq(64'(cmd.burst_num), 64'(rows), {tag, " burst_num"});
    endtask

    // ==================================================
    // tests

    task automatic test_reset();
        test_err_base = err_cnt;
        check_eq(64'(ins_ready), 64'd1, "ins_ready after reset");
        check_eq(64'(ibuf_start), 64'd0, "ibuf_start after reset");
        check_eq(64'(dbuf_start), 64'd0, "dbuf_start after reset");
        check_eq(64'(ibuf_ddr_sel), 64'd0, "ibuf_ddr_sel after reset");
        check_eq(64'(dbuf_ddr_sel), 64'd0, "dbuf_ddr_sel after reset");
        check_eq(64'(ddr1_ready_sel), 64'd0, "ddr1_ready_sel after reset");
        check_eq(64'(ddr1_start), 64'd0, "ddr1_start after reset");
        check_eq(64'(ddr2_start), 64'd0, "ddr2_start after reset");
        end_test("reset");
    endtask

    task automatic test_dw();
        layer_cfg_t  l;
        ins_word_u   w;
        logic [5:0]  id;
        logic [31:0] exp_mask;
        int          t;
        test_err_base = err_cnt;
        for (t = 0; t < 2; t++) begin
            l = rand_layer(t[0]);
            apply_layer(l);
            // single PE ids reach 31, groups of four only 7
            id       = (t == 1) ? 6'($urandom_range(31, 0)) : 6'($urandom_range(7, 0));
            exp_mask = (t == 1) ? (32'd1 << id) : (32'hf << (4 * id));
            w = make_ins(RD_OP_DW, id, 4'($urandom), 4'($urandom), 8'($urandom), $urandom);
            issue(w, 1'b0);
            check_eq(64'(ibuf_start), 64'd1, "dw ibuf_start");
            check_eq(64'(dbuf_start), 64'd0, "dw dbuf_start");
            check_eq(64'(ibuf_cfg.mode), 64'(l.layer_type), "dw mode");
            check_eq(64'(ibuf_cfg.idx_num), 64'(w.rd.size), "dw idx_num");
            check_eq(64'(ibuf_mask), 64'(exp_mask), "dw mask");
            check_eq(64'(ibuf_ddr_sel), 64'd1, "dw ibuf_ddr_sel");
            check_eq(64'(ddr1_start), 64'd1, "dw ddr1_start");
            check_eq(64'(ddr2_start), 64'd0, "dw ddr2_start");
            check_eq(64'(ddr1_cmd.st_addr), 64'(w.rd.st_addr), "dw st_addr");
            check_eq(64'(ddr1_cmd.burst), 64'(w.rd.size) + 64'd1, "dw burst");
            check_eq(64'(ddr1_cmd.step), 64'd0, "dw step");
            check_eq(64'(ddr1_cmd.burst_num), 64'd0, "dw burst_num");
            @(negedge clk);
            check_eq(64'(ibuf_start), 64'd0, "dw start lasts one cycle");
            check_eq(64'(ddr1_ready_sel), 64'd1, "dw ready select");
            wait_ready();
            check_eq(64'(ibuf_ddr_sel), 64'd0, "dw select cleared");
        end
        end_test("opcode DW");
    endtask

    task automatic test_dg(input logic group);
        layer_cfg_t l;
        ins_word_u  w;
        string      tag;
        test_err_base = err_cnt;
        tag = group ? "G" : "D";
        l   = rand_layer(1'($urandom));
        apply_layer(l);
        w = make_ins(group ? RD_OP_G : RD_OP_D, 6'($urandom), 4'($urandom), 4'($urandom),
                     8'($urandom), $urandom);
        issue(w, 1'b0);
        check_eq(64'(dbuf_start), 64'd1, {tag, " dbuf_start"});
        check_eq(64'(ibuf_start), 64'd0, {tag, " ibuf_start"});
        check_eq(64'(dbuf_mask), 64'({PE_NUM{1'b1}}), {tag, " mask"});
        check_eq(64'(dbuf_cfg.mode), 64'(l.layer_type), {tag, " mode"});
        check_eq(64'(dbuf_cfg.ch_num), 64'(l.in_ch_seg), {tag, " ch_num"});
        check_eq(64'(dbuf_cfg.row_num), 64'(w.rd.row_num), {tag, " row_num"});
        check_eq(64'(dbuf_cfg.pix_num), 64'(w.rd.pix_num), {tag, " pix_num"});
        check_eq(64'(dbuf_cfg.depool), 64'(l.depool), {tag, " depool"});
        check_eq(64'(dbuf_ddr_sel), group ? 64'd3 : 64'd1, {tag, " dbuf_ddr_sel"});
        check_eq(64'(ddr1_start), 64'd1, {tag, " ddr1_start"});
        check_strided(ddr1_cmd, w.rd.st_addr, w.rd.pix_num, l.in_ch_seg, l.in_img_width,
                      w.rd.row_num, {tag, " ddr1"});
        check_eq(64'(ddr2_start), 64'(group), {tag, " ddr2_start"});
        if (group) begin
            check_strided(ddr2_cmd, w.rd.st_addr, w.rd.pix_num, l.out_ch_seg,
                          l.out_img_width, w.rd.row_num, {tag, " ddr2"});
        end
        @(negedge clk);
        check_eq(64'(dbuf_start), 64'd0, {tag, " start lasts one cycle"});
        check_eq(64'(ddr1_ready_sel), 64'd0, {tag, " ready select"});
        wait_ready();
        check_eq(64'(dbuf_ddr_sel), 64'd0, {tag, " select cleared"});
        end_test({"opcode ", tag});
    endtask

    task automatic test_handshake();
        ins_word_u first;
        ins_word_u second;
        int        n;
        test_err_base = err_cnt;
        apply_layer(rand_layer(1'b1));
        first  = make_ins(RD_OP_DW, 6'd3, 4'd0, 4'd0, 8'd15, 32'h0000_1000);
        second = make_ins(RD_OP_D, 6'd0, 4'd2, 4'd1, 8'd0, 32'h0000_2000);
        issue(first, 1'b1);
        // valid stays up, now carrying the next word
        ins <= second;
        check_eq(64'(ibuf_start), 64'd1, "hs first start");
        n = 0;
        while (!ins_ready && n < TEST_CYCLES) begin
            check_eq(64'(dbuf_start), 64'd0, "hs second word taken while busy");
            @(negedge clk);
            n++;
        end
        check_eq(64'(ins_ready), 64'd1, "hs ins_ready returns");
        check_eq(64'(ibuf_done), 64'd1, "hs ready only after done");
        check_eq(64'(ibuf_ddr_sel), 64'd0, "hs ibuf select cleared");
        check_eq(64'(ddr1_ready_sel), 64'd1, "hs ready select after DW");
        @(negedge clk);
        ins_valid <= 1'b0;
        check_eq(64'(dbuf_start), 64'd1, "hs second start");
        check_eq(64'(ins_ready), 64'd0, "hs ins_ready low again");
        @(negedge clk);
        check_eq(64'(ddr1_ready_sel), 64'd0, "hs ready select after D");
        wait_ready();
        check_eq(64'(dbuf_ddr_sel), 64'd0, "hs dbuf select cleared");
        end_test("handshake");
    endtask

    task automatic test_unknown();
        ins_word_u w;
        test_err_base = err_cnt;
        w = make_ins(4'b1010, 6'($urandom), 4'($urandom), 4'($urandom), 8'($urandom),
                     $urandom);
        issue(w, 1'b0);
        check_eq(64'(ibuf_start), 64'd0, "unknown ibuf_start");
        check_eq(64'(dbuf_start), 64'd0, "unknown dbuf_start");
        check_eq(64'(ddr1_start), 64'd0, "unknown ddr1_start");
        check_eq(64'(ddr2_start), 64'd0, "unknown ddr2_start");
        wait_ready();
        check_eq(64'(ibuf_ddr_sel), 64'd0, "unknown ibuf_ddr_sel");
        check_eq(64'(dbuf_ddr_sel), 64'd0, "unknown dbuf_ddr_sel");
        end_test("unknown op");
    endtask

    // ==================================================
    // main sequence

    initial begin
        int seed_val;
        seed_val  = $urandom(SEED);
        rst       = 1'b1;
        ins_valid = 1'b0;
        ins       = '0;
        layer     = '0;
        err_cnt   = 0;
        test_cnt  = 0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_dw();
        test_dg(1'b0);
        test_dg(1'b1);
        test_handshake();
        test_unknown();
        $display("%0d tests, %0d mismatches", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/buf_config_gen.sv
`default_nettype none
`timescale 1ns/1ns

module buf_config_gen
    import rd_isa_pkg::*;
    import rd_cfg_pkg::*;
#(
    parameter int PE_NUM = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              fire,
    input  wire ins_word_u   ins,
    input  wire layer_cfg_t  layer,
    input  wire              ibuf_done,
    input  wire              dbuf_done,

    output logic              ibuf_start,
    output ibuf_cfg_t         ibuf_cfg,
    output logic [PE_NUM-1:0] ibuf_mask,
    output logic              ibuf_ddr_sel,

    output logic              dbuf_start,
    output dbuf_cfg_t         dbuf_cfg,
    output logic [PE_NUM-1:0] dbuf_mask,
    output logic [1:0]        dbuf_ddr_sel,

    output logic              ddr1_ready_sel
);

    logic ibuf_hit;
    logic dbuf_hit;
    logic ibuf_done_q;
    logic dbuf_done_q;
    logic ibuf_done_rise;
    logic dbuf_done_rise;

    assign ibuf_hit = fire && (ins.rd.opcode == RD_OP_DW);
    assign dbuf_hit = fire && (ins.rd.opcode == RD_OP_D || ins.rd.opcode == RD_OP_G);

    // ==================================================
    // start pulses

    always_ff @(posedge clk) begin
        if (rst) begin
            ibuf_start <= 1'b0;
            dbuf_start <= 1'b0;
        end else begin
            ibuf_start <= ibuf_hit;
            dbuf_start <= dbuf_hit;
        end
    end

    // ==================================================
    // buffer configuration

    always_ff @(posedge clk) begin
        if (ibuf_hit) begin
            ibuf_cfg.mode    <= layer.layer_type;
            ibuf_cfg.idx_num <= ins.rd.size;
            // single PE or a group of four, chosen by layer type
            if (layer.layer_type[0]) begin
                ibuf_mask <= PE_NUM'(1) << ins.rd.buf_id;
            end else begin
                ibuf_mask <= PE_NUM'(4'hf) << {ins.rd.buf_id, 2'b00};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dbuf_hit) begin
            dbuf_cfg.mode    <= layer.layer_type;
            dbuf_cfg.ch_num  <= layer.in_ch_seg;
            dbuf_cfg.row_num <= ins.rd.row_num;
            dbuf_cfg.pix_num <= ins.rd.pix_num;
            dbuf_cfg.depool  <= layer.depool;
            // data goes to every PE
            dbuf_mask        <= '1;
        end
    end

    // ==================================================
    // DDR select levels

    // engines idle with done high, so no edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ibuf_done_q <= 1'b1;
            dbuf_done_q <= 1'b1;
        end else begin
            ibuf_done_q <= ibuf_done;
            dbuf_done_q <= dbuf_done;
        end
    end

    assign ibuf_done_rise = ibuf_done & ~ibuf_done_q;
    assign dbuf_done_rise = dbuf_done & ~dbuf_done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ibuf_ddr_sel <= 1'b0;
        end else if (ibuf_hit) begin
            ibuf_ddr_sel <= 1'b1;
        end else if (ibuf_done_rise) begin
            ibuf_ddr_sel <= 1'b0;
        end
    end

    // group read also claims the second channel
    always_ff @(posedge clk) begin
        if (rst) begin
            dbuf_ddr_sel <= 2'b00;
        end else if (dbuf_hit) begin
            dbuf_ddr_sel <= (ins.rd.opcode == RD_OP_G) ? 2'b11 : 2'b01;
        end else if (dbuf_done_rise) begin
            dbuf_ddr_sel <= 2'b00;
        end
    end

    // channel 1 ready goes to whichever buffer started last
    always_ff @(posedge clk) begin
        if (rst) begin
            ddr1_ready_sel <= 1'b0;
        end else if (dbuf_start) begin
            ddr1_ready_sel <= 1'b0;
        end else if (ibuf_start) begin
            ddr1_ready_sel <= 1'b1;
        end
    end

    // ==================================================
    // checks

    a_one_start: assert property (@(posedge clk) disable iff (rst)
        !(ibuf_start && dbuf_start));

    // FSM holds off a second instruction right after a start
    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        (ibuf_start || dbuf_start) |=> !(ibuf_start || dbuf_start));

endmodule

`default_nettype wire

// File: verilog/ddr_read_planner.sv
`default_nettype none
`timescale 1ns/1ns

module ddr_read_planner
    import rd_isa_pkg::*;
    import rd_cfg_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              fire,
    input  wire ins_word_u   ins,
    input  wire layer_cfg_t  layer,

    output logic             ddr1_start,
    output ddr_cmd_t         ddr1_cmd,
    output logic             ddr2_start,
    output ddr_cmd_t         ddr2_cmd
);

    // layer sizes plus one, registered off the instruction path
    logic [4:0] in_seg_p1;
    logic [4:0] out_seg_p1;
    logic [8:0] in_width_p1;
    logic [8:0] out_width_p1;

    logic is_dw;
    logic is_dg;
    logic is_g;

    // strided row read, pix_num+1 pixels of seg_p1 channels per row
    function automatic ddr_cmd_t strided_cmd(
        input logic [DDR_ADDR_W-1:0] addr,
        input logic [3:0]            pix,
        input logic [4:0]            seg_p1,
        input logic [8:0]            width_p1,
        input logic [3:0]            rows
    );
        logic [4:0] pix_p1;
        ddr_cmd_t   cmd;
        pix_p1        = {1'b0, pix} + 5'd1;
        cmd.st_addr   = addr;
        cmd.burst     = (BURST_W'(pix_p1) * BURST_W'(seg_p1)) << LINE_SHIFT;
        cmd.step      = (DDR_ADDR_W'(pix_p1) * DDR_ADDR_W'(width_p1)) << LINE_SHIFT;
        cmd.burst_num = BURST_W'(rows);
        return cmd;
    endfunction

    always_ff @(posedge clk) begin
        in_seg_p1    <= {1'b0, layer.in_ch_seg} + 5'd1;
        out_seg_p1   <= {1'b0, layer.out_ch_seg} + 5'd1;
        in_width_p1  <= {1'b0, layer.in_img_width} + 9'd1;
        out_width_p1 <= {1'b0, layer.out_img_width} + 9'd1;
    end

    assign is_dw = (ins.rd.opcode == RD_OP_DW);
    assign is_g  = (ins.rd.opcode == RD_OP_G);
    assign is_dg = (ins.rd.opcode == RD_OP_D) || is_g;

    // ==================================================
    // channel 1

    always_ff @(posedge clk) begin
        if (rst) begin
            ddr1_start <= 1'b0;
        end else begin
            ddr1_start <= fire && (is_dw || is_dg);
        end
    end

    always_ff @(posedge clk) begin
        if (fire && is_dw) begin
            // weight index list is one contiguous burst
            ddr1_cmd.st_addr   <= ins.rd.st_addr;
            ddr1_cmd.burst     <= BURST_W'(ins.rd.size) + BURST_W'(1);
            ddr1_cmd.step      <= '0;
            ddr1_cmd.burst_num <= '0;
        end else if (fire && is_dg) begin
            ddr1_cmd <= strided_cmd(ins.rd.st_addr, ins.rd.pix_num, in_seg_p1,
                                    in_width_p1, ins.rd.row_num);
        end
    end

    // ==================================================
    // channel 2, second operand of a group read

    always_ff @(posedge clk) begin
        if (rst) begin
            ddr2_start <= 1'b0;
        end else begin
            ddr2_start <= fire && is_g;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && is_g) begin
            ddr2_cmd <= strided_cmd(ins.rd.st_addr, ins.rd.pix_num, out_seg_p1,
                                    out_width_p1, ins.rd.row_num);
        end
    end

    a_ddr2_with_ddr1: assert property (@(posedge clk) disable iff (rst)
        ddr2_start |-> ddr1_start);

endmodule

`default_nettype wire

// File: verilog/ins_dispatch_fsm.sv
`default_nettype none
`timescale 1ns/1ns

module ins_dispatch_fsm
    import rd_cfg_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  ins_valid,
    input  wire  ibuf_done,
    input  wire  dbuf_done,
    output logic ins_ready,
    output logic fire
);

    disp_state_t state;
    logic        ready_q;
    logic        all_done;

    assign all_done  = ibuf_done & dbuf_done;
    assign fire      = ins_valid & ready_q;
    assign ins_ready = ready_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (fire) state <= ST_CONF;
                // one cycle for the engines to pick up start
                ST_CONF: state <= ST_WORK;
                ST_WORK: if (all_done) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b1;
        end else if (fire) begin
            ready_q <= 1'b0;
        end else if (state == ST_WORK && all_done) begin
            ready_q <= 1'b1;
        end
    end

    // ==================================================
    // checks

    a_no_fire_busy: assert property (@(posedge clk) disable iff (rst)
        (state != ST_IDLE) |-> !fire);

    a_not_ready_conf: assert property (@(posedge clk) disable iff (rst)
        (state == ST_CONF) |-> !ins_ready);

endmodule

`default_nettype wire

// File: verilog/rd_cfg_pkg.sv
`default_nettype none

package rd_cfg_pkg;

    localparam int DDR_ADDR_W = 32;
    localparam int BURST_W    = 16;
    // bytes per pixel channel, as a shift
    localparam int LINE_SHIFT = 5;

    // quasi-static layer settings
    typedef struct packed {
        logic [3:0] layer_type;
        logic [7:0] in_img_width;
        logic [7:0] out_img_width;
        logic [3:0] in_ch_seg;
        logic [3:0] out_ch_seg;
        logic       depool;
    } layer_cfg_t;

    typedef struct packed {
        logic [3:0] mode;
        logic [7:0] idx_num;
    } ibuf_cfg_t;

    typedef struct packed {
        logic [3:0] mode;
        logic [3:0] ch_num;
        logic [3:0] row_num;
        logic [3:0] pix_num;
        logic       depool;
    } dbuf_cfg_t;

    // one DDR read request, burst_num rows spaced by step
    typedef struct packed {
        logic [DDR_ADDR_W-1:0] st_addr;
        logic [BURST_W-1:0]    burst;
        logic [DDR_ADDR_W-1:0] step;
        logic [BURST_W-1:0]    burst_num;
    } ddr_cmd_t;

    // dispatcher states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_CONF = 2'b01,
        ST_WORK = 2'b10
    } disp_state_t;

endpackage

`default_nettype wire

// File: verilog/rd_dispatch_top.sv
`default_nettype none
`timescale 1ns/1ns

module rd_dispatch_top
    import rd_isa_pkg::*;
    import rd_cfg_pkg::*;
#(
    parameter int PE_NUM = 32
) (
    input  wire              clk,
    input  wire              rst,

    input  wire              ins_valid,
    input  wire ins_word_u   ins,
    output logic             ins_ready,
    input  wire layer_cfg_t  layer,
    input  wire              ibuf_done,
    input  wire              dbuf_done,

    output logic              ibuf_start,
    output ibuf_cfg_t         ibuf_cfg,
    output logic [PE_NUM-1:0] ibuf_mask,
    output logic              ibuf_ddr_sel,
    output logic              dbuf_start,
    output dbuf_cfg_t         dbuf_cfg,
    output logic [PE_NUM-1:0] dbuf_mask,
    output logic [1:0]        dbuf_ddr_sel,
    output logic              ddr1_ready_sel,

    output logic              ddr1_start,
    output ddr_cmd_t          ddr1_cmd,
    output logic              ddr2_start,
    output ddr_cmd_t          ddr2_cmd
);

    logic fire;

    // instruction union must fill the whole word
    if ($bits(ins_word_u) != INST_W) begin : g_width_check
        $error("instruction union does not match INST_W");
    end

    ins_dispatch_fsm i_ins_dispatch_fsm (
        .clk       (clk),
        .rst       (rst),
        .ins_valid (ins_valid),
        .ibuf_done (ibuf_done),
        .dbuf_done (dbuf_done),
        .ins_ready (ins_ready),
        .fire      (fire)
    );

    buf_config_gen #(
        .PE_NUM (PE_NUM)
    ) i_buf_config_gen (
        .clk            (clk),
        .rst            (rst),
        .fire           (fire),
        .ins            (ins),
        .layer          (layer),
        .ibuf_done      (ibuf_done),
        .dbuf_done      (dbuf_done),
        .ibuf_start     (ibuf_start),
        .ibuf_cfg       (ibuf_cfg),
        .ibuf_mask      (ibuf_mask),
        .ibuf_ddr_sel   (ibuf_ddr_sel),
        .dbuf_start     (dbuf_start),
        .dbuf_cfg       (dbuf_cfg),
        .dbuf_mask      (dbuf_mask),
        .dbuf_ddr_sel   (dbuf_ddr_sel),
        .ddr1_ready_sel (ddr1_ready_sel)
    );

    ddr_read_planner i_ddr_read_planner (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .ins        (ins),
        .layer      (layer),
        .ddr1_start (ddr1_start),
        .ddr1_cmd   (ddr1_cmd),
        .ddr2_start (ddr2_start),
        .ddr2_cmd   (ddr2_cmd)
    );

endmodule

`default_nettype wire

// File: verilog/rd_isa_pkg.sv
`default_nettype none

package rd_isa_pkg;

    localparam int INST_W = 64;

    // read opcodes, anything else is accepted and ignored
    typedef enum logic [3:0] {
        RD_OP_D  = 4'b0000,
        RD_OP_G  = 4'b0001,
        RD_OP_DW = 4'b0100
    } opcode_t;

    // read form of the instruction
    typedef struct packed {
        logic [1:0]  pad;
        opcode_t     opcode;
        logic [5:0]  buf_id;
        logic [3:0]  unused;
        logic [3:0]  row_num;
        logic [3:0]  pix_num;
        logic [7:0]  size;
        logic [31:0] st_addr;
    } ins_rd_t;

    // parameter form, row/pix fields become one transfer size
    typedef struct packed {
        logic [1:0]  pad;
        opcode_t     opcode;
        logic [5:0]  buf_id;
        logic [11:0] p_size;
        logic [7:0]  size;
        logic [31:0] st_addr;
    } ins_prm_t;

    typedef union packed {
        ins_rd_t  rd;
        ins_prm_t prm;
    } ins_word_u;

endpackage

`default_nettype wire

// File: vlog.f
verilog/rd_isa_pkg.sv
verilog/rd_cfg_pkg.sv
verilog/ins_dispatch_fsm.sv
verilog/buf_config_gen.sv
verilog/ddr_read_planner.sv
verilog/rd_dispatch_top.sv
verif/tb_rd_dispatch.sv
